// File: rtl/i2c_cfg_defs.svh
//------------------------------
// i2c config master parameters
// bus timing defaults and field widths
//------------------------------
`ifndef I2C_CFG_DEFS_SVH
`define I2C_CFG_DEFS_SVH

//------------------------------
// clocking
//------------------------------
`define I2C_CFG_CLK_FREQ        100_000_000     // system clock, Hz
`define I2C_CFG_BUS_FREQ        400_000         // fast-mode scl, Hz

// system clocks per scl period
`define I2C_CFG_CLK_DIV         (`I2C_CFG_CLK_FREQ / `I2C_CFG_BUS_FREQ)

// sensor settling time after reset, 1 ms
`define I2C_CFG_POWERUP_CYCLES  (`I2C_CFG_CLK_FREQ / 1000)

//------------------------------
// field widths
//------------------------------
`define I2C_CFG_INDEX_W         8               // table index
`define I2C_CFG_BYTE_W          8               // one bus byte
`define I2C_CFG_REG_W           16              // sensor reg addr and data
`define I2C_CFG_DIV_W           16              // bit timer counter

`endif

// File: rtl/i2c_cfg_pkg.sv
//------------------------------
// i2c config master types
//------------------------------
`include "i2c_cfg_defs.svh"

package i2c_cfg_pkg;

    typedef logic [`I2C_CFG_BYTE_W-1:0]  byte_t;
    typedef logic [`I2C_CFG_REG_W-1:0]   reg_addr_t;
    typedef logic [`I2C_CFG_REG_W-1:0]   reg_data_t;
    typedef logic [`I2C_CFG_INDEX_W-1:0] cfg_index_t;
    typedef logic [`I2C_CFG_DIV_W-1:0]   div_cnt_t;

    // one table record, 40 bits, dev addr on top
    typedef struct packed {
        byte_t     dev_addr;    // 7-bit addr + r/w
        reg_addr_t reg_addr;
        reg_data_t reg_data;
    } cfg_entry_t;

    // per-bit timing strobes from the bit timer
    typedef struct packed {
        logic scl_phase;        // gated scl level
        logic shift_en;         // start of bit
        logic sample_en;        // mid bit
    } bit_strobe_t;

    typedef struct packed {
        logic       is_read;    // entry 0 only
        cfg_entry_t entry;
    } frame_cmd_t;

    // slot decode handed to the capture block
    typedef struct packed {
        logic ack_slot;         // slave ack bit
        logic data_slot;        // read data bit
        logic data_commit;      // both read bytes in
        logic frame_end;        // final stop
    } rx_ctl_t;

    typedef enum logic [3:0] {
        FS_IDLE,
        FS_START,
        FS_WR_BYTE,             // addr / reg / data bytes out
        FS_SLV_ACK,
        FS_RD_STOP,             // stop ahead of repeated frame
        FS_RD_IDLE,
        FS_START2,
        FS_RD_BYTE,
        FS_MST_ACK,
        FS_MST_NACK,
        FS_STOP
    } frame_state_t;

endpackage

// File: rtl/i2c_bit_timer.sv
//------------------------------
// i2c bit timer
// power-up delay, then scl phase and bit strobes
//------------------------------
`timescale 1ns/10ps

module i2c_bit_timer
    import i2c_cfg_pkg::*;
#(
    parameter int clk_div        = 250,
    parameter int powerup_cycles = 100_000
)
(
    input  logic        clk,
    input  logic        rst_n,
    output bit_strobe_t strobe,
    output logic        powered_up
);

    localparam int PWR_W = (powerup_cycles > 0) ? $clog2(powerup_cycles + 1) : 1;

    localparam div_cnt_t DIV_LAST = div_cnt_t'(clk_div - 1);
    localparam div_cnt_t DIV_HALF = div_cnt_t'(clk_div / 2);       // sample point
    localparam div_cnt_t DIV_Q1   = div_cnt_t'(clk_div / 4);       // scl rise
    localparam div_cnt_t DIV_Q3   = div_cnt_t'((3 * clk_div) / 4); // scl fall

    logic [PWR_W-1:0] pwr_cnt;
    div_cnt_t         div_cnt;

    //------------------------------
    // power-up settling
    //------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pwr_cnt    <= '0;
            powered_up <= 1'b0;
        end
        else if (!powered_up)
        begin
            if (pwr_cnt == PWR_W'(powerup_cycles))
                powered_up <= 1'b1;         // latches, never drops
            else
                pwr_cnt <= pwr_cnt + 1'b1;
        end
    end

    //------------------------------
    // phase counter and strobes
    //------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            strobe  <= '0;
        end
        else if (powered_up)
        begin
            div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
            strobe.shift_en  <= (div_cnt == '0);           // sda changes here
            strobe.sample_en <= (div_cnt == DIV_HALF);     // middle of scl high
            strobe.scl_phase <= (div_cnt >= DIV_Q1) && (div_cnt < DIV_Q3);
        end
    end

    // shift and sample must stay half a period apart
    a_strobe_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(strobe.shift_en && strobe.sample_en));

endmodule

// File: rtl/i2c_frame_fsm.sv
//------------------------------
// i2c frame engine
// bit-level write / read frames on scl and sda
//------------------------------
`timescale 1ns/10ps

module i2c_frame_fsm
    import i2c_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  bit_strobe_t strobe,
    input  logic        cmd_valid,
    input  frame_cmd_t  cmd,
    output logic        cmd_ready,
    output logic        scl,
    output logic        sda_out,
    output logic        sda_oe,
    output rx_ctl_t     rx_ctl
);

    frame_state_t state;
    frame_cmd_t   cmd_q;        // latched command
    byte_t        tx_byte;      // remaining bits, msb first
    byte_t        load_byte;
    logic [2:0]   bit_cnt;
    logic [2:0]   byte_idx;     // 0..4 write, 5 read addr, 6..7 read data
    logic [2:0]   load_idx;
    logic         sda_q;
    logic         take;
    logic         scl_gated;

    // byte order: dev, reg hi, reg lo, data hi, data lo, dev+read
    function automatic byte_t pick_byte(input cfg_entry_t e, input logic [2:0] idx);
        case (idx)
            3'd0:    pick_byte = {e.dev_addr[7:1], 1'b0};
            3'd1:    pick_byte = e.reg_addr[15:8];
            3'd2:    pick_byte = e.reg_addr[7:0];
            3'd3:    pick_byte = e.reg_data[15:8];
            3'd4:    pick_byte = e.reg_data[7:0];
            3'd5:    pick_byte = {e.dev_addr[7:1], 1'b1};  // r/w = read
            default: pick_byte = '1;
        endcase
    endfunction

    assign cmd_ready = (state == FS_IDLE) && strobe.shift_en;
    assign take      = cmd_valid && cmd_ready;
    assign load_idx  = (state == FS_SLV_ACK) ? byte_idx + 3'd1 : byte_idx;
    assign load_byte = pick_byte(cmd_q.entry, load_idx);

    always_ff @(posedge clk)
    begin
        if (take)
            cmd_q <= cmd;
    end

    //------------------------------
    // frame state machine, one step per bit
    //------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= FS_IDLE;
            sda_q    <= 1'b1;
            tx_byte  <= '0;
            bit_cnt  <= '0;
            byte_idx <= '0;
        end
        else if (strobe.shift_en)
        begin
            case (state)
                FS_IDLE:
                    if (take)
                    begin
                        state    <= FS_START;
                        sda_q    <= 1'b0;       // start, scl still high
                        byte_idx <= '0;
                    end
                FS_START, FS_START2:
                begin
                    state   <= FS_WR_BYTE;
                    sda_q   <= load_byte[7];
                    tx_byte <= {load_byte[6:0], 1'b0};
                    bit_cnt <= '0;
                end
                FS_WR_BYTE:
                    if (bit_cnt == 3'd7)
                    begin
                        state <= FS_SLV_ACK;
                        sda_q <= 1'b1;
                    end
                    else
                    begin
                        sda_q   <= tx_byte[7];
                        tx_byte <= {tx_byte[6:0], 1'b0};
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                FS_SLV_ACK:
                    if (!cmd_q.is_read && byte_idx == 3'd4)
                    begin
                        state <= FS_STOP;       // last write byte acked
                        sda_q <= 1'b0;
                    end
                    else if (cmd_q.is_read && byte_idx == 3'd2)
                    begin
                        state <= FS_RD_STOP;    // reg addr sent, turn around
                        sda_q <= 1'b0;
                    end
                    else if (byte_idx == 3'd5)
                    begin
                        state    <= FS_RD_BYTE;
                        byte_idx <= 3'd6;
                        bit_cnt  <= '0;
                        sda_q    <= 1'b1;
                    end
                    else
                    begin
                        state    <= FS_WR_BYTE;
                        byte_idx <= load_idx;
                        sda_q    <= load_byte[7];
                        tx_byte  <= {load_byte[6:0], 1'b0};
                        bit_cnt  <= '0;
                    end
                FS_RD_STOP:
                begin
                    state <= FS_RD_IDLE;
                    sda_q <= 1'b1;              // stop edge
                end
                FS_RD_IDLE:
                begin
                    state    <= FS_START2;
                    sda_q    <= 1'b0;           // repeated frame start
                    byte_idx <= 3'd5;
                end
                FS_RD_BYTE:
                    if (bit_cnt == 3'd7)
                    begin
                        state <= (byte_idx == 3'd6) ? FS_MST_ACK : FS_MST_NACK;
                        sda_q <= (byte_idx != 3'd6);    // ack first, nack second
                    end
                    else
                        bit_cnt <= bit_cnt + 3'd1;
                FS_MST_ACK:
                begin
                    state    <= FS_RD_BYTE;
                    byte_idx <= 3'd7;
                    bit_cnt  <= '0;
                    sda_q    <= 1'b1;
                end
                FS_MST_NACK:
                begin
                    state <= FS_STOP;
                    sda_q <= 1'b0;
                end
                default:                        // FS_STOP
                begin
                    state <= FS_IDLE;
                    sda_q <= 1'b1;              // stop edge, bus free
                end
            endcase
        end
    end

    //------------------------------
    // pins and slot decode
    //------------------------------
    assign scl_gated = (state == FS_WR_BYTE) || (state == FS_SLV_ACK) ||
                       (state == FS_RD_BYTE) || (state == FS_MST_ACK) ||
                       (state == FS_MST_NACK);
    assign scl     = scl_gated ? strobe.scl_phase : 1'b1;
    assign sda_out = sda_q;
    assign sda_oe  = !((state == FS_SLV_ACK) || (state == FS_RD_BYTE)); // slave owns sda

    assign rx_ctl.ack_slot    = (state == FS_SLV_ACK);
    assign rx_ctl.data_slot   = (state == FS_RD_BYTE);
    assign rx_ctl.data_commit = (state == FS_MST_NACK);
    assign rx_ctl.frame_end   = (state == FS_STOP);

    // slave owns sda only in an ack slot or a data byte of a read frame
    a_release_slot: assert property (@(posedge clk) disable iff (!rst_n)
        !sda_oe |-> rx_ctl.ack_slot ||
                    (rx_ctl.data_slot && cmd_q.is_read && byte_idx >= 3'd6));

endmodule

// File: rtl/i2c_rx_capture.sv
//------------------------------
// i2c receive capture
// ack sampling, read data, frame result
//------------------------------
`timescale 1ns/10ps

module i2c_rx_capture
    import i2c_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  bit_strobe_t strobe,
    input  rx_ctl_t     rx_ctl,
    input  logic        sda_in,
    output logic        frame_done,
    output logic        frame_nack,
    output reg_data_t   rdata
);

    logic      nack_flag;       // sticky over the whole frame
    reg_data_t rx_shift;

    // read bits, msb first, hi byte then lo byte
    always_ff @(posedge clk)
    begin
        if (strobe.sample_en && rx_ctl.data_slot)
            rx_shift <= {rx_shift[14:0], sda_in};
    end

    //------------------------------
    // ack flag and frame result
    //------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            nack_flag  <= 1'b0;
            frame_done <= 1'b0;
            frame_nack <= 1'b0;
            rdata      <= '0;
        end
        else
        begin
            frame_done <= 1'b0;                         // single-cycle pulse
            if (strobe.sample_en)
            begin
                if (rx_ctl.ack_slot)
                    nack_flag <= nack_flag | sda_in;    // high = no ack
                if (rx_ctl.data_commit)
                    rdata <= rx_shift;
                if (rx_ctl.frame_end)
                begin
                    frame_done <= 1'b1;
                    frame_nack <= nack_flag;
                    nack_flag  <= 1'b0;                 // fresh for next frame
                end
            end
        end
    end

endmodule

// File: rtl/i2c_cfg_sequencer.sv
//------------------------------
// config table sequencer
// walks the table, retries on nack
//------------------------------
`timescale 1ns/10ps

module i2c_cfg_sequencer
    import i2c_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       powered_up,
    input  cfg_entry_t cfg_entry,
    input  cfg_index_t cfg_size,
    input  logic       cmd_ready,
    input  logic       frame_done,
    input  logic       frame_nack,
    output cfg_index_t cfg_index,
    output logic       cmd_valid,
    output frame_cmd_t cmd,
    output logic       config_done
);

    logic in_flight;            // accepted, waiting for frame_done
    logic issue;

    assign config_done = (cfg_index == cfg_size);
    assign issue = powered_up && !cmd_valid && !in_flight && !config_done;

    // entry sampled once, held while the command waits
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            cmd.is_read <= (cfg_index == '0);
            cmd.entry   <= cfg_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cfg_index <= '0;
            cmd_valid <= 1'b0;
            in_flight <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
            begin
                cmd_valid <= 1'b0;
                in_flight <= 1'b1;
            end
            else if (issue)
                cmd_valid <= 1'b1;
            if (frame_done)
            begin
                in_flight <= 1'b0;
                if (!frame_nack)
                    cfg_index <= cfg_index + 1'b1;  // nack keeps index, resend
            end
        end
    end

    a_index_range: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_index <= cfg_size);

endmodule

// File: rtl/i2c_cfg_master.sv
//------------------------------
// i2c configuration master top
//------------------------------
`timescale 1ns/10ps
`include "i2c_cfg_defs.svh"

module i2c_cfg_master
    import i2c_cfg_pkg::*;
#(
    parameter int clk_div        = `I2C_CFG_CLK_DIV,
    parameter int powerup_cycles = `I2C_CFG_POWERUP_CYCLES
)
(
    input  logic       clk,
    input  logic       rst_n,
    // config table lookup
    input  cfg_entry_t cfg_entry,
    input  cfg_index_t cfg_size,
    output cfg_index_t cfg_index,
    output logic       config_done,
    output reg_data_t  rdata,       // entry 0 readback
    // bus pins
    input  logic       sda_in,
    output logic       scl,
    output logic       sda_out,
    output logic       sda_oe       // high = master drives sda
);

    bit_strobe_t strobe;
    logic        powered_up;
    logic        cmd_valid;
    logic        cmd_ready;
    frame_cmd_t  cmd;
    rx_ctl_t     rx_ctl;
    logic        frame_done;
    logic        frame_nack;

    i2c_bit_timer #(
        .clk_div        (clk_div),
        .powerup_cycles (powerup_cycles)
    ) u_bit_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .strobe     (strobe),
        .powered_up (powered_up)
    );

    i2c_cfg_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .powered_up  (powered_up),
        .cfg_entry   (cfg_entry),
        .cfg_size    (cfg_size),
        .cmd_ready   (cmd_ready),
        .frame_done  (frame_done),
        .frame_nack  (frame_nack),
        .cfg_index   (cfg_index),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .config_done (config_done)
    );

    i2c_frame_fsm u_frame_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .strobe    (strobe),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe),
        .rx_ctl    (rx_ctl)
    );

    i2c_rx_capture u_rx_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .strobe     (strobe),
        .rx_ctl     (rx_ctl),
        .sda_in     (sda_in),
        .frame_done (frame_done),
        .frame_nack (frame_nack),
        .rdata      (rdata)
    );

endmodule

// File: bench/i2c_slave_model.sv
//------------------------------
// behavioral i2c sensor slave
// register memory, ack, read return, nack injection
//------------------------------
`timescale 1ns/10ps

module i2c_slave_model
#(
    parameter logic [6:0] dev_addr = 7'h3c
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic scl,
    input  logic sda_out,
    input  logic sda_oe,
    output logic sda_in,
    output logic in_frame           // between start and stop
);

    logic [15:0] mem [0:65535];     // sensor register space
    logic        nack_pending;      // armed by the testbench, used once
    int          write_frames;      // frames that carried a data byte

    logic        drive_low;         // slave pulls sda
    logic        scl_q;
    logic        sda_q;
    logic        sda_now;
    logic        addr_ok;
    logic        reading;
    logic        ack_phase;         // ninth clock of a byte
    logic        frame_nacked;
    logic        mst_ack;
    int          bit_cnt;
    int          byte_cnt;
    logic [7:0]  rx_sr;
    logic [15:0] tx_sr;
    logic [15:0] ptr;               // register pointer, kept over stop
    logic [7:0]  data_hi;

    // wired and of master and slave
    assign sda_in = (sda_oe ? sda_out : 1'b1) & !drive_low;

    initial
    begin
        for (int a = 0; a < 65536; a++)
            mem[a] = a[15:0] ^ 16'hc35a;
    end

    // bus sampled on the falling clock, clear of the master's edges
    always @(negedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scl_q        = 1'b1;
            sda_q        = 1'b1;
            in_frame     = 1'b0;
            drive_low    = 1'b0;
            nack_pending = 1'b0;
            write_frames = 0;
        end
        else
        begin
            sda_now = sda_in;
            if (scl && scl_q && sda_q && !sda_now)
            begin
                in_frame     = 1'b1;        // start
                bit_cnt      = 0;
                byte_cnt     = 0;
                addr_ok      = 1'b0;
                reading      = 1'b0;
                ack_phase    = 1'b0;
                frame_nacked = 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda_now)
            begin
                if (in_frame && addr_ok && !reading && byte_cnt >= 4)
                    write_frames++;         // stop after data
                in_frame = 1'b0;
            end
            else if (in_frame && scl && !scl_q)
            begin
                if (bit_cnt < 8)
                begin
                    rx_sr   = {rx_sr[6:0], sda_now};
                    bit_cnt = bit_cnt + 1;
                end
                else
                    mst_ack = !sda_now;     // master ack, read only
            end
            else if (in_frame && !scl && scl_q)
            begin
                if (ack_phase)
                begin
                    ack_phase = 1'b0;
                    bit_cnt   = 0;
                    drive_low = 1'b0;
                    if (reading && (byte_cnt == 1 || mst_ack))
                    begin
                        if (byte_cnt > 1)
                            tx_sr = tx_sr << 1;     // msb of next byte
                        drive_low = !tx_sr[15];
                        byte_cnt  = byte_cnt + 1;
                    end
                end
                else if (bit_cnt == 8)
                begin
                    ack_phase = 1'b1;
                    drive_low = 1'b0;               // read: master acks
                    if (!reading && (byte_cnt == 0 || addr_ok))
                    begin
                        case (byte_cnt)
                            0:
                            begin
                                addr_ok = (rx_sr[7:1] == dev_addr);
                                reading = rx_sr[0] && addr_ok;
                                tx_sr   = mem[ptr];
                            end
                            1: ptr[15:8] = rx_sr;
                            2: ptr[7:0]  = rx_sr;
                            3:
                            begin
                                data_hi      = rx_sr;
                                frame_nacked = nack_pending;    // injected nack
                                nack_pending = 1'b0;
                            end
                            4:
                                if (!frame_nacked)
                                    mem[ptr] = {data_hi, rx_sr};
                            default: ;
                        endcase
                        drive_low = addr_ok && !frame_nacked;
                        byte_cnt  = byte_cnt + 1;
                    end
                end
                else if (reading && bit_cnt > 0)
                begin
                    tx_sr     = tx_sr << 1;
                    drive_low = !tx_sr[15];
                end
            end
            scl_q = scl;
            sda_q = sda_now;
        end
    end

endmodule

// File: bench/tb_i2c_cfg.sv
//------------------------------
// testbench for the i2c config master
//------------------------------
`timescale 1ns/10ps

module tb_i2c_cfg
    import i2c_cfg_pkg::*;
();

    localparam int         CLK_DIV     = 40;
    localparam int         PWR_CYCLES  = 64;
    localparam int         MAX_CYCLES  = 40_000;   // ~4x the longest table run
    localparam int         TABLE_DEPTH = 16;
    localparam logic [6:0] SENSOR_ADDR = 7'h3c;

    logic        clk;
    logic        rst_n;
    cfg_entry_t  cfg_entry;
    cfg_index_t  cfg_size;
    cfg_index_t  cfg_index;
    logic        config_done;
    reg_data_t   rdata;
    logic        sda_in;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    logic        slave_busy;

    cfg_entry_t  cfg_table [0:TABLE_DEPTH-1];
    logic [31:0] rng_state;
    int          cycle_cnt;

    i2c_cfg_master #(
        .clk_div        (CLK_DIV),
        .powerup_cycles (PWR_CYCLES)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_entry   (cfg_entry),
        .cfg_size    (cfg_size),
        .cfg_index   (cfg_index),
        .config_done (config_done),
        .rdata       (rdata),
        .sda_in      (sda_in),
        .scl         (scl),
        .sda_out     (sda_out),
        .sda_oe      (sda_oe)
    );

    i2c_slave_model #(
        .dev_addr (SENSOR_ADDR)
    ) slave (
        .clk      (clk),
        .rst_n    (rst_n),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in),
        .in_frame (slave_busy)
    );

    always #5 clk = ~clk;

    // table lookup, entry follows the index
    always @(posedge clk)
    begin
        #1;
        cfg_entry = cfg_table[cfg_index];
    end

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout: config table not finished after %0d cycles", cycle_cnt);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    //------------------------------
    // helpers
    //------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s: expected %0h, actual %0h", label, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;                                 // outputs settled
    endtask

    // random table, low address byte = index keeps registers apart
    task automatic fill_table();
        for (int i = 0; i < TABLE_DEPTH; i++)
        begin
            rng_state = xorshift32(rng_state);
            cfg_table[i].dev_addr = {SENSOR_ADDR, 1'b0};
            cfg_table[i].reg_addr = {rng_state[31:24], i[7:0]};
            cfg_table[i].reg_data = rng_state[15:0];
        end
    endtask

    // new table, readback value preloaded, 3-cycle reset
    task automatic start_run(input cfg_index_t size, output reg_data_t preload);
        fill_table();
        rng_state = xorshift32(rng_state);
        preload   = rng_state[23:8];
        slave.mem[cfg_table[0].reg_addr] = preload;
        @(posedge clk);
        #1;
        rst_n    = 1'b0;
        cfg_size = size;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic wait_table_done();
        while (!config_done)
            tick();
        while (slave_busy)
            tick();                         // last stop reaches the slave
    endtask

    task automatic check_table_writes(input string name, input cfg_index_t size);
        for (int i = 1; i < size; i++)
            check_value($sformatf("%s reg %h", name, cfg_table[i].reg_addr),
                        cfg_table[i].reg_data, slave.mem[cfg_table[i].reg_addr]);
        check_value({name, " config_done"}, 1, config_done);
        check_value({name, " cfg_index"}, size, cfg_index);
    endtask

    //------------------------------
    // tests
    //------------------------------
    task automatic test_idle_after_reset();
        reg_data_t preload;
        start_run(8'd6, preload);
        #1;
        check_value("idle scl", 1, scl);
        check_value("idle sda_out", 1, sda_out);
        check_value("idle sda_oe", 1, sda_oe);
        check_value("idle config_done", 0, config_done);
        check_value("idle cfg_index", 0, cfg_index);
        check_value("idle rdata", 0, rdata);
    endtask

    task automatic test_register_read();
        reg_data_t preload;
        start_run(8'd3, preload);
        while (cfg_index == '0)
            tick();
        check_value("register_read rdata", preload, rdata);
    endtask

    task automatic test_write_table();
        reg_data_t preload;
        start_run(8'd6, preload);
        wait_table_done();
        check_table_writes("write_table", 8'd6);
        check_value("write_table frames", 5, slave.write_frames);
        check_value("write_table rdata", preload, rdata);
    endtask

    task automatic test_nack_retry();
        reg_data_t preload;
        start_run(8'd5, preload);
        slave.nack_pending = 1'b1;          // first write gets refused
        wait_table_done();
        check_table_writes("nack_retry", 8'd5);
        check_value("nack_retry frames", 5, slave.write_frames);
        check_value("nack_retry rdata", preload, rdata);
    endtask

    task automatic test_empty_tail();
        reg_data_t preload;
        start_run(8'd1, preload);
        wait_table_done();
        check_value("empty_tail rdata", preload, rdata);
        check_value("empty_tail cfg_index", 1, cfg_index);
        check_value("empty_tail frames", 0, slave.write_frames);
    endtask

    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cfg_size  = 8'd1;
        cfg_entry = '0;
        rng_state = 32'h8987;
        cycle_cnt = 0;
        for (int i = 0; i < TABLE_DEPTH; i++)
            cfg_table[i] = '0;
        test_idle_after_reset();
        test_register_read();
        test_write_table();
        test_nack_retry();
        test_empty_tail();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+rtl
rtl/i2c_cfg_pkg.sv
rtl/i2c_bit_timer.sv
rtl/i2c_frame_fsm.sv
rtl/i2c_rx_capture.sv
rtl/i2c_cfg_sequencer.sv
rtl/i2c_cfg_master.sv
bench/i2c_slave_model.sv
bench/tb_i2c_cfg.sv
